// ==== vlog.f ====
logic/dbg_pkg.sv
logic/dbg_select.sv
logic/dbg_bus_module.sv
logic/dbg_cpu_module.sv
logic/dbg_top.sv
tests/dbg_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module dbg_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vdbg_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

exit 0

// ==== tests/dbg_tb.sv ====
// Scans driven as TAP strobes; the DUT uses a long ack timeout so one full scan fits in a request
`timescale 1ns/1ps
`default_nettype none

module dbg_tb
  import dbg_pkg::*;
();

  // Long enough for a select scan to land inside an outstanding request
  localparam int ACK_TIMEOUT = 80;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_ENTRY = 400;
  localparam int MAX_POLLS = 8;

  // Compare masks for the captured frame
  localparam dr_t M_FLAGS = 53'h3;
  localparam dr_t M_BUS = 53'h3_FFFF_FFFF;
  localparam dr_t M_CPU = 53'h7;
  localparam dr_t M_FULL = {DR_LEN{1'b1}};

  typedef enum logic [1:0] {
    K_SEL,
    K_CMD,
    K_BP
  } kind_t;

  // No status scan, one scan, or scans until busy clears
  typedef enum logic [1:0] {
    ST_NONE,
    ST_ONCE,
    ST_IDLE
  } status_mode_t;

  typedef struct packed {
    kind_t        kind;
    opcode_t      code;
    word_t        arg;
    status_mode_t mode;
    dr_t          exp;
    dr_t          mask;
    logic [1:0]   pins;
  } entry_t;

  logic  tck_i = 1'b0;
  logic  rst_i;
  logic  tdi_i;
  logic  shift_dr_i;
  logic  capture_dr_i;
  logic  update_dr_i;
  logic  debug_select_i;
  word_t bus_dat_i;
  logic  bus_ack_i;
  logic  bus_err_i;
  logic  cpu_bp_i;
  logic  tdo_o;
  logic  bus_cyc_o;
  logic  bus_we_o;
  word_t bus_adr_o;
  word_t bus_dat_o;
  logic  cpu_stall_o;
  logic  cpu_rst_o;

  entry_t stim_q[$];
  word_t  mem [64];
  logic [1:0] ack_delay = 2'd0;
  logic   req_seen = 1'b0;
  int     value_errors = 0;
  int     other_errors = 0;
  int     cycles = 0;
  int     cycle_limit = 1000;

  // Expected request, tracked from the commands sent
  word_t  exp_adr = '0;
  logic   exp_we = 1'b0;
  word_t  exp_wdat = '0;

  dbg_top #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) dbg_top_i (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .bus_dat_i      (bus_dat_i),
    .bus_ack_i      (bus_ack_i),
    .bus_err_i      (bus_err_i),
    .cpu_bp_i       (cpu_bp_i),
    .tdo_o          (tdo_o),
    .bus_cyc_o      (bus_cyc_o),
    .bus_we_o       (bus_we_o),
    .bus_adr_o      (bus_adr_o),
    .bus_dat_o      (bus_dat_o),
    .cpu_stall_o    (cpu_stall_o),
    .cpu_rst_o      (cpu_rst_o)
  );

  // 8 ns TCK
  always #4 tck_i = ~tck_i;

  // Run limit grows with the table
  always @(posedge tck_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////

  // Nibble F errors, nibble E never answers, rest acks after 0..3 cycles
  always @(posedge tck_i) begin
    #1;
    bus_ack_i = 1'b0;
    bus_err_i = 1'b0;
    if (!bus_cyc_o) begin
      req_seen = 1'b0;
    end else begin
      if (!req_seen) begin
        req_seen = 1'b1;
        ack_delay = 2'($urandom % 4);
        // First request cycle carries the commanded address, direction and data
        if (bus_adr_o !== exp_adr) begin
          report_value("bus_adr_o", dr_t'(bus_adr_o), dr_t'(exp_adr));
        end
        if (bus_we_o !== exp_we) begin
          report_value("bus_we_o", dr_t'(bus_we_o), dr_t'(exp_we));
        end
        if (exp_we && bus_dat_o !== exp_wdat) begin
          report_value("bus_dat_o", dr_t'(bus_dat_o), dr_t'(exp_wdat));
        end
      end
      if (ack_delay != 2'd0) begin
        ack_delay = ack_delay - 2'd1;
      end else if (bus_adr_o[31:28] == 4'hF) begin
        bus_err_i = 1'b1;
      end else if (bus_adr_o[31:28] != 4'hE) begin
        bus_ack_i = 1'b1;
        // Completed access moves on to the next word
        exp_adr = exp_adr + 32'd4;
        if (bus_we_o) begin
          mem[bus_adr_o[7:2]] = bus_dat_o;
        end else begin
          bus_dat_i = mem[bus_adr_o[7:2]];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Frame and status helpers
  //////////////////////////////////////////////////

  function automatic dr_t make_frame(input kind_t kind, input opcode_t code, input word_t arg);
    dr_t f;
    f = '0;
    if (kind == K_SEL) begin
      f[SEL_BIT] = 1'b1;
      f[MOD_ID_HI:MOD_ID_LO] = code[1:0];
    end else begin
      f[OPC_HI:OPC_LO] = code;
      f[ARG_HI:ARG_LO] = arg;
    end
    return f;
  endfunction

  // Busy 0, then error, then read data
  function automatic dr_t bus_word(input word_t data, input logic err);
    dr_t s;
    s = '0;
    s[1] = err;
    s[33:2] = data;
    return s;
  endfunction

  function automatic dr_t cpu_word(input logic stall, input logic rst, input logic bp);
    dr_t s;
    s = '0;
    s[0] = stall;
    s[1] = rst;
    s[2] = bp;
    return s;
  endfunction

  task automatic add_entry(input kind_t kind, input opcode_t code, input word_t arg,
                           input status_mode_t mode, input dr_t exp, input dr_t mask,
                           input logic [1:0] pins);
    entry_t e;
    e = '{kind, code, arg, mode, exp, mask, pins};
    stim_q.push_back(e);
  endtask

  task automatic report_value(input string name, input dr_t got, input dr_t exp);
    value_errors++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  // Capture, 53 shifts LSB first, update; tdo sampled before each shift edge
  task automatic scan_dr(input dr_t frame, output dr_t captured);
    captured = '0;
    @(posedge tck_i);
    #1;
    capture_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    capture_dr_i = 1'b0;
    shift_dr_i = 1'b1;
    for (int i = 0; i < DR_LEN; i++) begin
      tdi_i = frame[i];
      captured[i] = tdo_o;
      @(posedge tck_i);
      #1;
    end
    shift_dr_i = 1'b0;
    update_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    update_dr_i = 1'b0;
  endtask

  // Status scans carry an all-zero frame with the no-op opcode 0
  task automatic read_status(input logic wait_idle, output dr_t st);
    int polls;
    polls = 1;
    scan_dr('0, st);
    while (wait_idle && st[0] && polls < MAX_POLLS) begin
      scan_dr('0, st);
      polls++;
    end
    if (wait_idle && st[0]) begin
      other_errors++;
      $display("Bus module still busy after %0d status scans", polls);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    entry_t      e;
    dr_t         status;
    dr_t         unused;
    int unsigned seed_ret;
    seed_ret = $urandom(32'hb4c8_2ca5);
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);
    end
    rst_i = 1'b1;
    tdi_i = 1'b0;
    shift_dr_i = 1'b0;
    capture_dr_i = 1'b0;
    update_dr_i = 1'b0;
    debug_select_i = 1'b0;
    bus_dat_i = '0;
    bus_ack_i = 1'b0;
    bus_err_i = 1'b0;
    cpu_bp_i = 1'b0;
    status = '0;
    repeat (RESET_CYCLES) @(posedge tck_i);
    #1;
    rst_i = 1'b0;
    debug_select_i = 1'b1;

    // Outputs idle out of reset
    if (bus_cyc_o !== 1'b0) report_value("bus_cyc_o", dr_t'(bus_cyc_o), '0);
    if (cpu_stall_o !== 1'b0) report_value("cpu_stall_o", dr_t'(cpu_stall_o), '0);
    if (cpu_rst_o !== 1'b0) report_value("cpu_rst_o", dr_t'(cpu_rst_o), '0);
    if (tdo_o !== 1'b0) report_value("tdo_o", dr_t'(tdo_o), '0);

    // Bus writes at word 4..6, then read back through the auto-increment
    add_entry(K_SEL, 4'd0, '0, ST_ONCE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_SET_ADDR, 32'h10, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_WRITE, 32'h1111_1111, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_WRITE, 32'h2222_2222, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_WRITE, 32'h3333_3333, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_SET_ADDR, 32'h10, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_IDLE, bus_word(32'h1111_1111, 1'b0), M_BUS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_IDLE, bus_word(32'h2222_2222, 1'b0), M_BUS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_IDLE, bus_word(32'h3333_3333, 1'b0), M_BUS, 2'b00);
    // Error region then silent region with the flag cleared by the next capture
    add_entry(K_CMD, OPC_SET_ADDR, 32'hF000_0000, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_IDLE, bus_word('0, 1'b1), M_FLAGS, 2'b00);
    add_entry(K_CMD, 4'd0, '0, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_SET_ADDR, 32'hE000_0000, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_IDLE, bus_word('0, 1'b1), M_FLAGS, 2'b00);
    add_entry(K_CMD, 4'd0, '0, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    // CPU stall and reset bits, then breakpoint
    add_entry(K_SEL, 4'd1, '0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b0), M_CPU, 2'b00);
    add_entry(K_CMD, OPC_CPU_WRITE, 32'h1, ST_ONCE, cpu_word(1'b1, 1'b0, 1'b0), M_CPU, 2'b01);
    add_entry(K_CMD, OPC_CPU_WRITE, 32'h3, ST_ONCE, cpu_word(1'b1, 1'b1, 1'b0), M_CPU, 2'b11);
    add_entry(K_CMD, OPC_CPU_WRITE, 32'h0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b0), M_CPU, 2'b00);
    add_entry(K_BP, 4'd0, '0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b1), M_CPU, 2'b01);
    add_entry(K_CMD, OPC_CPU_WRITE, 32'h0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b0), M_CPU, 2'b00);
    add_entry(K_CMD, OPC_CPU_READ, '0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b0), M_CPU, 2'b00);
    // Select during an outstanding request is ignored
    add_entry(K_SEL, 4'd0, '0, ST_ONCE, bus_word(32'h3333_3333, 1'b0), M_BUS, 2'b00);
    add_entry(K_CMD, OPC_SET_ADDR, 32'hE000_0000, ST_IDLE, bus_word('0, 1'b0), M_FLAGS, 2'b00);
    add_entry(K_CMD, OPC_READ, '0, ST_NONE, '0, '0, 2'b00);
    add_entry(K_SEL, 4'd1, '0, ST_IDLE, bus_word(32'h3333_3333, 1'b1), M_BUS, 2'b00);
    // Unused id 2 keeps tdo low for the whole scan
    add_entry(K_SEL, 4'd2, '0, ST_ONCE, '0, M_FULL, 2'b00);
    add_entry(K_SEL, 4'd1, '0, ST_ONCE, cpu_word(1'b0, 1'b0, 1'b0), M_CPU, 2'b00);

    cycle_limit = RESET_CYCLES + CYCLES_PER_ENTRY * stim_q.size();

    for (int n = 0; n < stim_q.size(); n++) begin
      e = stim_q[n];
      case (e.kind)
        K_BP: begin
          cpu_bp_i = 1'b1;
          @(posedge tck_i);
          #1;
          cpu_bp_i = 1'b0;
        end
        default: begin
          if (e.kind == K_CMD && e.code == OPC_SET_ADDR) begin
            exp_adr = e.arg;
          end
          if (e.kind == K_CMD && (e.code == OPC_WRITE || e.code == OPC_READ)) begin
            exp_we = (e.code == OPC_WRITE);
            exp_wdat = e.arg;
          end
          scan_dr(make_frame(e.kind, e.code, e.arg), unused);
          // Cycle opens in the clock after the update
          if (e.kind == K_CMD && (e.code == OPC_WRITE || e.code == OPC_READ) &&
              bus_cyc_o !== 1'b1) begin
            report_value("bus_cyc_o", dr_t'(bus_cyc_o), dr_t'(1'b1));
          end
        end
      endcase
      case (e.mode)
        ST_ONCE: read_status(1'b0, status);
        ST_IDLE: read_status(1'b1, status);
        default: status = '0;
      endcase
      if (e.mode != ST_NONE && (status & e.mask) !== (e.exp & e.mask)) begin
        report_value($sformatf("status entry %0d", n), status & e.mask, e.exp & e.mask);
      end
      if (cpu_stall_o !== e.pins[0]) begin
        report_value($sformatf("cpu_stall_o entry %0d", n), dr_t'(cpu_stall_o), dr_t'(e.pins[0]));
      end
      if (cpu_rst_o !== e.pins[1]) begin
        report_value($sformatf("cpu_rst_o entry %0d", n), dr_t'(cpu_rst_o), dr_t'(e.pins[1]));
      end
    end

    // Writes landed at consecutive words
    for (int i = 0; i < 3; i++) begin
      if (mem[4 + i] !== word_t'(32'h1111_1111 * (i + 1))) begin
        report_value($sformatf("mem[%0d]", 4 + i), dr_t'(mem[4 + i]),
                     dr_t'(word_t'(32'h1111_1111 * (i + 1))));
      end
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/dbg_top.sv ====
// Expects TAP state strobes from an external controller, all logic runs on tck_i
`timescale 1ns/1ps
`default_nettype none

module dbg_top
  import dbg_pkg::*;
#(
  parameter int ACK_TIMEOUT = 16
) (
  input  wire        tck_i,
  input  wire        rst_i,
  input  wire        tdi_i,
  input  wire        shift_dr_i,
  input  wire        capture_dr_i,
  input  wire        update_dr_i,
  input  wire        debug_select_i,
  input  wire word_t bus_dat_i,
  input  wire        bus_ack_i,
  input  wire        bus_err_i,
  input  wire        cpu_bp_i,
  output logic       tdo_o,
  output logic       bus_cyc_o,
  output logic       bus_we_o,
  output word_t      bus_adr_o,
  output word_t      bus_dat_o,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  // Shared DR and per-module select
  dr_t  data_reg;
  logic bus_sel;
  logic cpu_sel;

  // Returned from the modules
  logic bus_tdo;
  logic cpu_tdo;
  logic bus_inhibit;
  logic cpu_inhibit;

  //////////////////////////////////////////////////
  // Select logic
  //////////////////////////////////////////////////

  dbg_select dbg_select_i (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .bus_inhibit_i  (bus_inhibit),
    .cpu_inhibit_i  (cpu_inhibit),
    .bus_tdo_i      (bus_tdo),
    .cpu_tdo_i      (cpu_tdo),
    .data_reg_o     (data_reg),
    .bus_sel_o      (bus_sel),
    .cpu_sel_o      (cpu_sel),
    .tdo_o          (tdo_o)
  );

  //////////////////////////////////////////////////
  // Debug modules
  //////////////////////////////////////////////////

  dbg_bus_module #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) dbg_bus_module_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .data_reg_i      (data_reg),
    .module_select_i (bus_sel),
    .debug_select_i  (debug_select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .bus_dat_i       (bus_dat_i),
    .bus_ack_i       (bus_ack_i),
    .bus_err_i       (bus_err_i),
    .tdo_o           (bus_tdo),
    .inhibit_o       (bus_inhibit),
    .bus_cyc_o       (bus_cyc_o),
    .bus_we_o        (bus_we_o),
    .bus_adr_o       (bus_adr_o),
    .bus_dat_o       (bus_dat_o)
  );

  dbg_cpu_module dbg_cpu_module_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .data_reg_i      (data_reg),
    .module_select_i (cpu_sel),
    .debug_select_i  (debug_select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .cpu_bp_i        (cpu_bp_i),
    .tdo_o           (cpu_tdo),
    .inhibit_o       (cpu_inhibit),
    .cpu_stall_o     (cpu_stall_o),
    .cpu_rst_o       (cpu_rst_o)
  );

endmodule

`default_nettype wire

// ==== logic/dbg_cpu_module.sv ====
// CPU control on tck_i; a breakpoint stalls the CPU until the next CPU write
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_module
  import dbg_pkg::*;
(
  input  wire      tck_i,
  input  wire      rst_i,
  input  wire dr_t data_reg_i,
  input  wire      module_select_i,
  input  wire      debug_select_i,
  input  wire      capture_dr_i,
  input  wire      shift_dr_i,
  input  wire      update_dr_i,
  input  wire      cpu_bp_i,
  output logic     tdo_o,
  output logic     inhibit_o,
  output logic     cpu_stall_o,
  output logic     cpu_rst_o
);

  // Stall, reset, breakpoint seen
  localparam int CPU_STATUS_LEN = 3;

  logic                      stall_bit;
  logic                      rst_bit;
  logic                      bp_flag;
  logic [CPU_STATUS_LEN-1:0] status_sr;

  logic    sel_valid;
  logic    cmd_valid;
  logic    cpu_write;
  opcode_t opcode;

  //////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////

  assign sel_valid = debug_select_i & module_select_i;
  assign cmd_valid = sel_valid & update_dr_i & ~data_reg_i[SEL_BIT];
  assign opcode    = data_reg_i[OPC_HI:OPC_LO];

  // Only the write opcode touches the control bits
  assign cpu_write = cmd_valid & (opcode == OPC_CPU_WRITE);

  //////////////////////////////////////////////////
  // Control register and breakpoint flag
  //////////////////////////////////////////////////

  // Arg bit 0 is stall, bit 1 is reset
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_bit <= 1'b0;
      rst_bit   <= 1'b0;
    end else if (cpu_write) begin
      stall_bit <= data_reg_i[ARG_LO];
      rst_bit   <= data_reg_i[ARG_LO+1];
    end
  end

  // A breakpoint in the write cycle is kept
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bp_flag <= 1'b0;
    end else if (cpu_bp_i) begin
      bp_flag <= 1'b1;
    end else if (cpu_write) begin
      bp_flag <= 1'b0;
    end
  end

  assign cpu_stall_o = stall_bit | bp_flag;
  assign cpu_rst_o   = rst_bit;

  // Never blocks a module change
  assign inhibit_o = 1'b0;

  //////////////////////////////////////////////////
  // Status shift register
  //////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_sr <= '0;
    end else if (sel_valid && capture_dr_i) begin
      status_sr <= {bp_flag, rst_bit, stall_bit};
    end else if (sel_valid && shift_dr_i) begin
      status_sr <= {1'b0, status_sr[CPU_STATUS_LEN-1:1]};
    end
  end

  assign tdo_o = status_sr[0];

endmodule

`default_nettype wire

// ==== logic/dbg_bus_module.sv ====
// Single-word bus master on tck_i; commands arriving while busy are dropped
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_module
  import dbg_pkg::*;
#(
  parameter int ACK_TIMEOUT = 16
) (
  input  wire        tck_i,
  input  wire        rst_i,
  input  wire dr_t   data_reg_i,
  input  wire        module_select_i,
  input  wire        debug_select_i,
  input  wire        capture_dr_i,
  input  wire        shift_dr_i,
  input  wire        update_dr_i,
  input  wire word_t bus_dat_i,
  input  wire        bus_ack_i,
  input  wire        bus_err_i,
  output logic       tdo_o,
  output logic       inhibit_o,
  output logic       bus_cyc_o,
  output logic       bus_we_o,
  output word_t      bus_adr_o,
  output word_t      bus_dat_o
);

  // Wide enough to hold ACK_TIMEOUT
  localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] TMO_LAST = CNT_W'(ACK_TIMEOUT - 1);

  bus_state_t            state;
  logic [CNT_W-1:0]      ack_cnt;
  logic                  err_flag;
  word_t                 rd_data;
  logic [STATUS_LEN-1:0] status_sr;

  logic    sel_valid;
  logic    cmd_valid;
  opcode_t opcode;
  word_t   arg;
  logic    busy;
  logic    timeout;
  logic    err_set;
  logic    start;

  //////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////

  assign sel_valid = debug_select_i & module_select_i;
  assign cmd_valid = sel_valid & update_dr_i & ~data_reg_i[SEL_BIT];
  assign opcode    = data_reg_i[OPC_HI:OPC_LO];
  assign arg       = data_reg_i[ARG_HI:ARG_LO];

  assign busy = (state == REQ);

  // Only reads and writes open a bus cycle
  assign start = (state == IDLE) & cmd_valid & ((opcode == OPC_WRITE) | (opcode == OPC_READ));

  // Last cycle of the ack window
  assign timeout = busy & (ack_cnt == TMO_LAST);

  // Bus error or no answer in time, an ack in the same cycle wins
  assign err_set = busy & ~bus_ack_i & (bus_err_i | timeout);

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state     <= IDLE;
      ack_cnt   <= '0;
      bus_we_o  <= 1'b0;
      bus_adr_o <= '0;
    end else begin
      case (state)
        IDLE: begin
          ack_cnt <= '0;
          if (cmd_valid) begin
            case (opcode)
              OPC_SET_ADDR: begin
                bus_adr_o <= arg;
              end
              OPC_WRITE: begin
                bus_we_o <= 1'b1;
                state    <= REQ;
              end
              OPC_READ: begin
                bus_we_o <= 1'b0;
                state    <= REQ;
              end
              default: begin
                state <= IDLE;
              end
            endcase
          end
        end
        REQ: begin
          ack_cnt <= ack_cnt + 1'b1;
          if (bus_ack_i) begin
            // Completed access, step to next word
            bus_adr_o <= bus_adr_o + 32'd4;
            state     <= IDLE;
          end else if (err_set) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Cycle stays up for the whole request
  assign bus_cyc_o = busy;
  assign inhibit_o = busy;

  // Write data taken with the command
  always_ff @(posedge tck_i) begin
    if (start && opcode == OPC_WRITE) begin
      bus_dat_o <= arg;
    end
  end

  // Read data sampled on the ack cycle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rd_data <= '0;
    end else if (busy && bus_ack_i && !bus_we_o) begin
      rd_data <= bus_dat_i;
    end
  end

  //////////////////////////////////////////////////
  // Status and serial output
  //////////////////////////////////////////////////

  // Sticky until reported, a new error beats the clear
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      err_flag <= 1'b0;
    end else if (err_set) begin
      err_flag <= 1'b1;
    end else if (sel_valid && capture_dr_i) begin
      err_flag <= 1'b0;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_sr <= '0;
    end else if (sel_valid && capture_dr_i) begin
      status_sr <= {rd_data, err_flag, busy};
    end else if (sel_valid && shift_dr_i) begin
      status_sr <= {1'b0, status_sr[STATUS_LEN-1:1]};
    end
  end

  assign tdo_o = status_sr[0];

endmodule

`default_nettype wire

// ==== logic/dbg_select.sv ====
// Module id changes only on select frames and only while no module inhibits it
`timescale 1ns/1ps
`default_nettype none

module dbg_select
  import dbg_pkg::*;
(
  input  wire  tck_i,
  input  wire  rst_i,
  input  wire  tdi_i,
  input  wire  shift_dr_i,
  input  wire  update_dr_i,
  input  wire  debug_select_i,
  input  wire  bus_inhibit_i,
  input  wire  cpu_inhibit_i,
  input  wire  bus_tdo_i,
  input  wire  cpu_tdo_i,
  output dr_t  data_reg_o,
  output logic bus_sel_o,
  output logic cpu_sel_o,
  output logic tdo_o
);

  mod_id_t mod_id;
  logic    inhibit;
  logic    sel_update;

  //////////////////////////////////////////////////
  // Input shift register
  //////////////////////////////////////////////////

  // LSB first, new bit enters at the top
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      data_reg_o <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      data_reg_o <= {tdi_i, data_reg_o[DR_LEN-1:1]};
    end
  end

  //////////////////////////////////////////////////
  // Module id register
  //////////////////////////////////////////////////

  // Any busy module holds the current selection
  assign inhibit = bus_inhibit_i | cpu_inhibit_i;

  // Select frames only, commands go to the modules
  assign sel_update = debug_select_i & update_dr_i & data_reg_o[SEL_BIT] & ~inhibit;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      mod_id <= MOD_BUS;
    end else if (sel_update) begin
      mod_id <= data_reg_o[MOD_ID_HI:MOD_ID_LO];
    end
  end

  // One-hot selects, ids 2 and 3 select nothing
  assign bus_sel_o = (mod_id == MOD_BUS);
  assign cpu_sel_o = (mod_id == MOD_CPU);

  // TDO mux by module id
  always_comb begin
    case (mod_id)
      MOD_BUS: tdo_o = bus_tdo_i;
      MOD_CPU: tdo_o = cpu_tdo_i;
      default: tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/dbg_pkg.sv ====
// Fixed 53-bit DR shifted LSB first; single-word bus access only and one CPU
`default_nettype none

package dbg_pkg;

  //////////////////////////////////////////////////
  // Data register layout
  //////////////////////////////////////////////////

  localparam int DR_LEN = 53;
  typedef logic [DR_LEN-1:0] dr_t;

  // Set for a module-select frame
  localparam int SEL_BIT = 52;

  // Module id field of a select frame
  localparam int MOD_ID_HI = 51;
  localparam int MOD_ID_LO = 50;
  typedef logic [MOD_ID_HI-MOD_ID_LO:0] mod_id_t;

  localparam mod_id_t MOD_BUS = 2'd0;
  localparam mod_id_t MOD_CPU = 2'd1;

  // Command frame fields
  localparam int OPC_HI = 51;
  localparam int OPC_LO = 48;
  typedef logic [OPC_HI-OPC_LO:0] opcode_t;

  localparam int ARG_HI = 47;
  localparam int ARG_LO = 16;

  // Bus address and data
  typedef logic [31:0] word_t;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  localparam opcode_t OPC_SET_ADDR  = 4'd1;
  localparam opcode_t OPC_WRITE     = 4'd2;
  localparam opcode_t OPC_READ      = 4'd3;
  localparam opcode_t OPC_CPU_WRITE = 4'd4;
  localparam opcode_t OPC_CPU_READ  = 4'd5;

  // Busy, error, then 32 bits of read data
  localparam int STATUS_LEN = 34;

  typedef enum logic {
    IDLE,
    REQ
  } bus_state_t;

endpackage

`default_nettype wire
